// ==== rtl/noc_fifo_pkg.sv ====
// ------------------------------
// NoC input buffer definitions
// ------------------------------

package noc_fifo_pkg;

  // ------------------------------
  // Widths and sizes
  // ------------------------------
  localparam int DATA_WIDTH = 32;
  localparam int TYPE_WIDTH = 3;

  // Slot count and one-hot pointer width, one slot is kept free
  localparam int DEPTH = 4;

  // Owed credits for drops that collide with a read
  localparam int CREDIT_CNT_WIDTH = 2;

  // ------------------------------
  // Types
  // ------------------------------
  typedef logic [DATA_WIDTH-1:0] flit_t;
  typedef logic [DEPTH-1:0] slot_ptr_t;

  // Flit type field sits in the top bits of the flit
  typedef enum logic [TYPE_WIDTH-1:0] {
    FLIT_HEADER = 3'b001,
    FLIT_BODY   = 3'b010,
    FLIT_TAIL   = 3'b100
  } flit_type_e;

  // Packet drop FSM, one-hot
  typedef enum logic [4:0] {
    ST_IDLE   = 5'b00001,
    ST_HEADER = 5'b00010,
    ST_BODY   = 5'b00100,
    ST_TAIL   = 5'b01000,
    ST_DROP   = 5'b10000
  } drop_state_e;

  // Tail type with even parity in bit 0
  localparam flit_t FAKE_TAIL = 32'h80000001;

endpackage

// ==== rtl/flit_buffer.sv ====
// ------------------------------
// Circular flit buffer
// ------------------------------

`timescale 1ns/100ps

module flit_buffer (
  input  logic                clk,
  input  logic                reset,
  input  logic                store_flit,
  input  logic                store_fake_tail,
  input  noc_fifo_pkg::flit_t rx,
  input  logic                read_en,
  output noc_fifo_pkg::flit_t data_out,
  output logic                empty_out,
  output logic                read_accepted
);

  noc_fifo_pkg::flit_t     mem [noc_fifo_pkg::DEPTH];
  noc_fifo_pkg::slot_ptr_t write_ptr;
  noc_fifo_pkg::slot_ptr_t read_ptr;
  noc_fifo_pkg::flit_t     write_data;
  logic                    write_en;
  logic                    full;

  // ------------------------------
  // Flags
  // ------------------------------
  assign empty_out = (read_ptr == write_ptr);

  // Full when the write pointer sits one slot behind the read pointer
  assign full = (write_ptr == {read_ptr[0], read_ptr[noc_fifo_pkg::DEPTH-1:1]});

  assign write_en      = store_flit & ~full;
  assign read_accepted = read_en & ~empty_out;

  // Fake tail replaces the broken flit in the same slot
  assign write_data = store_fake_tail ? noc_fifo_pkg::FAKE_TAIL : rx;

  // ------------------------------
  // Pointers and memory
  // ------------------------------
  always_ff @(posedge clk) begin
    if (!reset) begin
      write_ptr <= noc_fifo_pkg::slot_ptr_t'(1);
      read_ptr  <= noc_fifo_pkg::slot_ptr_t'(1);
      for (int i = 0; i < noc_fifo_pkg::DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else begin
      if (write_en) begin
        for (int i = 0; i < noc_fifo_pkg::DEPTH; i++) begin
          if (write_ptr[i]) begin
            mem[i] <= write_data;
          end
        end
        write_ptr <= {write_ptr[noc_fifo_pkg::DEPTH-2:0], write_ptr[noc_fifo_pkg::DEPTH-1]};
      end
      if (read_accepted) begin
        read_ptr <= {read_ptr[noc_fifo_pkg::DEPTH-2:0], read_ptr[noc_fifo_pkg::DEPTH-1]};
      end
    end
  end

  // Head flit, straight from the slot under the read pointer
  always_comb begin
    data_out = mem[0];
    for (int i = 0; i < noc_fifo_pkg::DEPTH; i++) begin
      if (read_ptr[i]) begin
        data_out = mem[i];
      end
    end
  end

  // ------------------------------
  // Checks
  // ------------------------------
  a_ptr_onehot: assert property (
    @(posedge clk) disable iff (!reset)
    $onehot(write_ptr) && $onehot(read_ptr)
  );

  // An accepted write never wraps the write pointer onto the read pointer
  a_no_write_when_full: assert property (
    @(posedge clk) disable iff (!reset)
    write_en |=> !empty_out
  );

endmodule

// ==== rtl/packet_drop_fsm.sv ====
// ------------------------------
// Parity check and packet drop
// ------------------------------

`timescale 1ns/100ps

module packet_drop_fsm (
  input  logic                clk,
  input  logic                reset,
  input  logic                valid_in,
  input  noc_fifo_pkg::flit_t rx,
  output logic                store_flit,
  output logic                store_fake_tail,
  output logic                fake_credit,
  output logic                fault_info,
  output logic                health_info
);

  noc_fifo_pkg::drop_state_e state;
  noc_fifo_pkg::drop_state_e state_next;
  noc_fifo_pkg::flit_type_e  flit_type;
  logic                      parity_ok;
  logic                      healthy;
  logic                      faulty;
  logic                      fault_info_next;

  // ------------------------------
  // Flit decode
  // ------------------------------
  // Even parity over bits 31..1 lands in bit 0
  assign parity_ok = ((^rx[noc_fifo_pkg::DATA_WIDTH-1:1]) == rx[0]);
  assign healthy   = valid_in & parity_ok;
  assign faulty    = valid_in & ~parity_ok;

  assign flit_type = noc_fifo_pkg::flit_type_e'(
    rx[noc_fifo_pkg::DATA_WIDTH-1 -: noc_fifo_pkg::TYPE_WIDTH]);

  // ------------------------------
  // Next state and store decision
  // ------------------------------
  always_comb begin
    state_next      = state;
    store_flit      = 1'b0;
    store_fake_tail = 1'b0;
    fake_credit     = 1'b0;
    fault_info_next = 1'b0;
    health_info     = 1'b0;

    case (state)
      noc_fifo_pkg::ST_IDLE: begin
        if (healthy) begin
          store_flit = 1'b1;
          state_next = noc_fifo_pkg::ST_HEADER;
        end else if (faulty) begin
          fake_credit     = 1'b1;
          fault_info_next = 1'b1;
          state_next      = noc_fifo_pkg::ST_DROP;
        end
      end

      noc_fifo_pkg::ST_HEADER: begin
        if (healthy) begin
          store_flit = 1'b1;
          if (flit_type == noc_fifo_pkg::FLIT_BODY) begin
            state_next = noc_fifo_pkg::ST_BODY;
          end else if (flit_type == noc_fifo_pkg::FLIT_TAIL) begin
            state_next = noc_fifo_pkg::ST_TAIL;
          end
        end else if (faulty) begin
          // Close the packet downstream, the fake tail takes this flit's credit
          store_flit      = 1'b1;
          store_fake_tail = 1'b1;
          fault_info_next = 1'b1;
          state_next      = noc_fifo_pkg::ST_DROP;
        end
      end

      noc_fifo_pkg::ST_BODY: begin
        if (healthy) begin
          store_flit = 1'b1;
          if (flit_type == noc_fifo_pkg::FLIT_TAIL) begin
            health_info = 1'b1;
            state_next  = noc_fifo_pkg::ST_TAIL;
          end
        end else if (faulty) begin
          store_flit      = 1'b1;
          store_fake_tail = 1'b1;
          fault_info_next = 1'b1;
          state_next      = noc_fifo_pkg::ST_DROP;
        end
      end

      noc_fifo_pkg::ST_TAIL: begin
        if (healthy) begin
          store_flit = 1'b1;
          if (flit_type == noc_fifo_pkg::FLIT_HEADER) begin
            state_next = noc_fifo_pkg::ST_HEADER;
          end
        end else if (faulty) begin
          // Packet already closed, nothing to patch
          fake_credit     = 1'b1;
          fault_info_next = 1'b1;
          state_next      = noc_fifo_pkg::ST_DROP;
        end else begin
          state_next = noc_fifo_pkg::ST_IDLE;
        end
      end

      noc_fifo_pkg::ST_DROP: begin
        if (healthy && flit_type == noc_fifo_pkg::FLIT_HEADER) begin
          store_flit = 1'b1;
          state_next = noc_fifo_pkg::ST_HEADER;
        end else if (healthy && flit_type == noc_fifo_pkg::FLIT_TAIL) begin
          // End of the broken packet, still owes its credit
          fake_credit = 1'b1;
          state_next  = noc_fifo_pkg::ST_IDLE;
        end else if (valid_in) begin
          fake_credit = 1'b1;
          if (flit_type == noc_fifo_pkg::FLIT_HEADER) begin
            fault_info_next = 1'b1;
          end
        end
      end

      default: begin
        state_next = noc_fifo_pkg::ST_IDLE;
      end
    endcase
  end

  // ------------------------------
  // State and fault register
  // ------------------------------
  always_ff @(posedge clk) begin
    if (!reset) begin
      state      <= noc_fifo_pkg::ST_IDLE;
      fault_info <= 1'b0;
    end else begin
      state      <= state_next;
      fault_info <= fault_info_next;
    end
  end

  // ------------------------------
  // Checks
  // ------------------------------
  a_state_onehot: assert property (
    @(posedge clk) disable iff (!reset)
    $onehot(state)
  );

  a_fake_tail_stored: assert property (
    @(posedge clk) disable iff (!reset)
    store_fake_tail |-> store_flit
  );

endmodule

// ==== rtl/credit_counter.sv ====
// ------------------------------
// Credit return
// ------------------------------

`timescale 1ns/100ps

module credit_counter (
  input  logic clk,
  input  logic reset,
  input  logic read_accepted,
  input  logic fake_credit,
  output logic credit_out
);

  logic [noc_fifo_pkg::CREDIT_CNT_WIDTH-1:0] owed;
  logic [noc_fifo_pkg::CREDIT_CNT_WIDTH-1:0] owed_next;
  logic                                      credit_next;

  // One credit per cycle, a second one in the same cycle is owed
  always_comb begin
    owed_next   = owed;
    credit_next = read_accepted | fake_credit;
    if (read_accepted && fake_credit) begin
      owed_next = owed + 1'b1;
    end else if (!read_accepted && !fake_credit && owed != '0) begin
      owed_next   = owed - 1'b1;
      credit_next = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!reset) begin
      owed       <= '0;
      credit_out <= 1'b0;
    end else begin
      owed       <= owed_next;
      credit_out <= credit_next;
    end
  end

  // Upstream holds at most DEPTH-1 credits, so the counter cannot wrap
  a_owed_no_overflow: assert property (
    @(posedge clk) disable iff (!reset)
    (read_accepted && fake_credit) |-> (owed != '1)
  );

endmodule

// ==== rtl/fifo_credit_based.sv ====
// ------------------------------
// Router port input buffer
// ------------------------------

`timescale 1ns/100ps

module fifo_credit_based (
  input  logic                clk,
  input  logic                reset,
  input  noc_fifo_pkg::flit_t rx,
  input  logic                valid_in,
  input  logic                read_en,
  output noc_fifo_pkg::flit_t data_out,
  output logic                empty_out,
  output logic                credit_out,
  output logic                fault_info,
  output logic                health_info
);

  logic store_flit;
  logic store_fake_tail;
  logic fake_credit;
  logic read_accepted;

  // ------------------------------
  // Parity check and drop FSM
  // ------------------------------
  packet_drop_fsm packet_drop_fsm_i (
    .clk             (clk),
    .reset           (reset),
    .valid_in        (valid_in),
    .rx              (rx),
    .store_flit      (store_flit),
    .store_fake_tail (store_fake_tail),
    .fake_credit     (fake_credit),
    .fault_info      (fault_info),
    .health_info     (health_info)
  );

  // ------------------------------
  // Flit storage
  // ------------------------------
  // Write gating on full happens here only
  flit_buffer flit_buffer_i (
    .clk             (clk),
    .reset           (reset),
    .store_flit      (store_flit),
    .store_fake_tail (store_fake_tail),
    .rx              (rx),
    .read_en         (read_en),
    .data_out        (data_out),
    .empty_out       (empty_out),
    .read_accepted   (read_accepted)
  );

  // ------------------------------
  // Credits back upstream
  // ------------------------------
  credit_counter credit_counter_i (
    .clk           (clk),
    .reset         (reset),
    .read_accepted (read_accepted),
    .fake_credit   (fake_credit),
    .credit_out    (credit_out)
  );

endmodule

// ==== tb/fifo_credit_based_tb.sv ====
// ------------------------------
// Input buffer testbench
// ------------------------------

`timescale 1ns/100ps

module fifo_credit_based_tb;

  localparam int PERIOD         = 40;
  localparam int RESET_CYCLES   = 5;
  localparam int SEED           = 32'h9e468b27;
  localparam int START_CREDITS  = 3;
  localparam int TRAFFIC_CYCLES = 2000;
  localparam int FILL_TIMEOUT   = 50;
  localparam int DRAIN_TIMEOUT  = 100;

  localparam logic [2:0] T_HEADER = 3'b001;
  localparam logic [2:0] T_BODY   = 3'b010;
  localparam logic [2:0] T_TAIL   = 3'b100;

  typedef enum {M_IDLE, M_HEADER, M_BODY, M_TAIL, M_DROP} model_state_e;

  logic                clk;
  logic                reset;
  noc_fifo_pkg::flit_t rx;
  logic                valid_in;
  logic                read_en;
  noc_fifo_pkg::flit_t data_out;
  logic                empty_out;
  logic                credit_out;
  logic                fault_info;
  logic                health_info;

  // Reference model state
  model_state_e        m_state;
  noc_fifo_pkg::flit_t m_q[$];
  int                  m_owed;
  logic                exp_credit;
  logic                exp_fault;

  // Sender side and bookkeeping
  noc_fifo_pkg::flit_t pkt[$];
  int   sender_credits;
  int   credits_seen;
  int   n_reads;
  int   n_drops;
  int   n_fake_tails;
  int   n_fault_pulses;
  int   n_health_pulses;
  int   n_checks;
  int   n_errors;
  int   test_errors;
  logic timed_out;

  fifo_credit_based fifo_credit_based_i (
    .clk         (clk),
    .reset       (reset),
    .rx          (rx),
    .valid_in    (valid_in),
    .read_en     (read_en),
    .data_out    (data_out),
    .empty_out   (empty_out),
    .credit_out  (credit_out),
    .fault_info  (fault_info),
    .health_info (health_info)
  );

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // ------------------------------
  // Helpers
  // ------------------------------
  task automatic compare_signal(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
    n_checks++;
    assert (actual === expected) else begin
      $display("ERR %s expected %h got %h", name, expected, actual);
      n_errors++;
    end
  endtask

  task automatic report_test(input string name);
    $display("%s: done, %0d errors", name, n_errors - test_errors);
    test_errors = n_errors;
  endtask

  function automatic noc_fifo_pkg::flit_t make_flit(input logic [2:0] ftype, input logic flip);
    noc_fifo_pkg::flit_t f;
    logic [31:0]         rnd;
    rnd  = $urandom();
    f    = {ftype, rnd[27:0], 1'b0};
    f[0] = ^f[31:1];
    if (flip) begin
      f[0] = ~f[0];
    end
    return f;
  endfunction

  // Header, 0 to 3 bodies and a tail, a few with broken parity
  task automatic build_packet(input int n_bodies, input logic allow_faults);
    pkt.push_back(make_flit(T_HEADER, allow_faults && ($urandom() % 12 == 0)));
    for (int i = 0; i < n_bodies; i++) begin
      pkt.push_back(make_flit(T_BODY, allow_faults && ($urandom() % 12 == 0)));
    end
    pkt.push_back(make_flit(T_TAIL, allow_faults && ($urandom() % 12 == 0)));
  endtask

  // ------------------------------
  // One clock cycle with model
  // ------------------------------
  task automatic run_cycle(input logic v, input noc_fifo_pkg::flit_t flit, input logic ren);
    logic                ok;
    logic                bad;
    logic                store;
    logic                fake_tail;
    logic                fake_cr;
    logic                fault_next;
    logic                health;
    logic                racc;
    logic                full;
    logic [2:0]          ftype;
    model_state_e        nxt;
    @(negedge clk);
    valid_in = v;
    rx       = flit;
    read_en  = ren;
    #(PERIOD / 4);
    ok         = v && ((^flit[31:1]) == flit[0]);
    bad        = v && !ok;
    ftype      = flit[31:29];
    store      = 1'b0;
    fake_tail  = 1'b0;
    fake_cr    = 1'b0;
    fault_next = 1'b0;
    health     = 1'b0;
    nxt        = m_state;
    case (m_state)
      M_IDLE: begin
        if (ok) begin
          store = 1'b1;
          nxt   = M_HEADER;
        end else if (bad) begin
          fake_cr    = 1'b1;
          fault_next = 1'b1;
          nxt        = M_DROP;
        end
      end
      M_HEADER, M_BODY: begin
        if (ok) begin
          store = 1'b1;
          if (ftype == T_TAIL) begin
            health = (m_state == M_BODY);
            nxt    = M_TAIL;
          end else if (ftype == T_BODY) begin
            nxt = M_BODY;
          end
        end else if (bad) begin
          store      = 1'b1;
          fake_tail  = 1'b1;
          fault_next = 1'b1;
          nxt        = M_DROP;
        end
      end
      M_TAIL: begin
        if (ok) begin
          store = 1'b1;
          nxt   = (ftype == T_HEADER) ? M_HEADER : M_TAIL;
        end else if (bad) begin
          fake_cr    = 1'b1;
          fault_next = 1'b1;
          nxt        = M_DROP;
        end else begin
          nxt = M_IDLE;
        end
      end
      default: begin
        if (ok && ftype == T_HEADER) begin
          store = 1'b1;
          nxt   = M_HEADER;
        end else if (ok && ftype == T_TAIL) begin
          fake_cr = 1'b1;
          nxt     = M_IDLE;
        end else if (v) begin
          fake_cr    = 1'b1;
          fault_next = (ftype == T_HEADER);
        end
      end
    endcase

    compare_signal("empty_out", m_q.size() == 0, empty_out);
    if (m_q.size() > 0) begin
      compare_signal("data_out", m_q[0], data_out);
    end
    compare_signal("credit_out", exp_credit, credit_out);
    compare_signal("fault_info", exp_fault, fault_info);
    compare_signal("health_info", health, health_info);
    if (credit_out) begin
      sender_credits++;
      credits_seen++;
    end
    n_fault_pulses  += fault_info;
    n_health_pulses += health_info;

    // Buffer and credit update at the coming rising edge
    full = (m_q.size() == START_CREDITS);
    racc = ren && (m_q.size() > 0);
    assert (!(store && full)) else begin
      $display("A flit arrived while the buffer was full, the sender ignored its credits");
      n_errors++;
    end
    if (racc) begin
      void'(m_q.pop_front());
      n_reads++;
    end
    if (store && !full) begin
      m_q.push_back(fake_tail ? noc_fifo_pkg::FAKE_TAIL : flit);
    end
    n_fake_tails += fake_tail;
    n_drops      += fake_cr;
    exp_credit = racc || fake_cr;
    if (racc && fake_cr) begin
      m_owed++;
    end else if (!racc && !fake_cr && m_owed > 0) begin
      m_owed--;
      exp_credit = 1'b1;
    end
    exp_fault = fault_next;
    m_state   = nxt;
  endtask

  // Read until every flit is out and every credit is back
  task automatic drain_buffer(input string what);
    int cycles;
    cycles = 0;
    while (!(m_q.size() == 0 && m_owed == 0 && !exp_credit) && cycles < DRAIN_TIMEOUT) begin
      run_cycle(1'b0, $urandom(), 1'b1);
      cycles++;
    end
    if (!(m_q.size() == 0 && m_owed == 0 && !exp_credit)) begin
      $display("Timeout while draining the buffer after %s", what);
      timed_out = 1'b1;
    end
  endtask

  // ------------------------------
  // Test sequence
  // ------------------------------
  initial begin
    int                  cycles;
    logic                send;
    noc_fifo_pkg::flit_t f;
    reset    = 1'b0;
    rx       = '0;
    valid_in = 1'b0;
    read_en  = 1'b0;
    void'($urandom(SEED));
    m_state = M_IDLE;
    m_owed = 0;
    exp_credit = 1'b0;
    exp_fault = 1'b0;
    sender_credits = START_CREDITS;
    credits_seen = 0;
    n_reads = 0;
    n_drops = 0;
    n_fake_tails = 0;
    n_fault_pulses = 0;
    n_health_pulses = 0;
    n_checks = 0;
    n_errors = 0;
    test_errors = 0;
    timed_out = 1'b0;

    repeat (RESET_CYCLES) @(negedge clk);
    reset = 1'b1;
    #(PERIOD / 4);
    compare_signal("empty_out", 1, empty_out);
    compare_signal("credit_out", 0, credit_out);
    compare_signal("fault_info", 0, fault_info);
    compare_signal("health_info", 0, health_info);
    report_test("reset_values");

    // Random packets, gaps and read_en
    for (int i = 0; i < TRAFFIC_CYCLES; i++) begin
      if (pkt.size() == 0) begin
        build_packet($urandom_range(0, 3), 1'b1);
      end
      send = (sender_credits > 0) && ($urandom() % 4 != 0);
      f    = $urandom();
      if (send) begin
        f = pkt.pop_front();
        sender_credits--;
      end
      run_cycle(send, f, $urandom() % 3 != 0);
    end
    pkt.delete();
    drain_buffer("random traffic");
    report_test("random_traffic");

    // Fill with read_en low, then hold and drain
    if (!timed_out) begin
      build_packet(1, 1'b0);
      cycles = 0;
      while (m_q.size() < START_CREDITS && cycles < FILL_TIMEOUT) begin
        send = (sender_credits > 0) && (pkt.size() > 0);
        f    = $urandom();
        if (send) begin
          f = pkt.pop_front();
          sender_credits--;
        end
        run_cycle(send, f, 1'b0);
        cycles++;
      end
      if (m_q.size() < START_CREDITS) begin
        $display("Timeout while filling the buffer with read_en low");
        timed_out = 1'b1;
      end
      for (int i = 0; i < 10 && !timed_out; i++) begin
        run_cycle(1'b0, $urandom(), 1'b0);
        compare_signal("empty_out", 0, empty_out);
      end
      if (!timed_out) begin
        drain_buffer("back-pressure");
        #(PERIOD / 2);
        compare_signal("empty_out", 1, empty_out);
      end
      report_test("back_pressure");
    end

    // Credit balance and fault coverage
    if (!timed_out) begin
      compare_signal("credit_out count", n_reads + n_drops, credits_seen);
      compare_signal("sender credits", START_CREDITS, sender_credits);
      assert (n_fault_pulses > 0 && n_fake_tails > 0) else begin
        $display("No parity fault after a header was exercised");
        n_errors++;
      end
      assert (n_health_pulses > 0) else begin
        $display("No healthy tail after a body was seen");
        n_errors++;
      end
      report_test("credit_balance");
    end

    $display("checks %0d, errors %0d, reads %0d, drops %0d", n_checks, n_errors,
             n_reads, n_drops);
    if (n_errors == 0 && !timed_out) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
rtl/noc_fifo_pkg.sv
rtl/flit_buffer.sv
rtl/packet_drop_fsm.sv
rtl/credit_counter.sv
rtl/fifo_credit_based.sv
tb/fifo_credit_based_tb.sv

// ==== Makefile ====
# Verilator build and run for the router port input buffer

LOG = sim.log

all: run

build:
	verilator --binary --timing --assert -j 0 -f sources.f \
		--top-module fifo_credit_based_tb -Mdir obj_dir -o sim

run: build
	./obj_dir/sim | tee $(LOG)
	grep -q "Simulation completed successfully" $(LOG)

lint:
	verilator --lint-only -Wall --timing -f sources.f \
		--top-module fifo_credit_based_tb

clean:
	rm -rf obj_dir $(LOG)

.PHONY: all build run lint clean
